/* Makefile */
# Verilator build and run of the reorder buffer testbench

.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal --top-module rob_tb -f sources.f
	@out="$$(./obj_dir/Vrob_tb)"; echo "$$out"; echo "$$out" | grep -qF '*** PASSED ***'

clean:
	rm -rf obj_dir

/* dv/rob_assert.sv */
// concurrent checks on the reorder buffer top level
// commit slot order, flush against ready, slot 0 of a dispatch group

`timescale 1ns/1ns

`include "rob_cfg.svh"

module rob_assert (
	input logic                    clock,
	input logic                    reset,
	input rob_pkg::rob_disp_t      disp,
	input logic [`ROB_THREADS-1:0] disp_ready,
	input logic [`ROB_THREADS-1:0] flush,
	input rob_pkg::rob_commit_t    commit [`ROB_COMMIT_W]
);
	import rob_pkg::*;

	a_commit_order: assert property (@(posedge clock) disable iff (reset)
		commit[1].valid |-> commit[0].valid)
		else $error("commit slot 1 valid while slot 0 is idle");

	a_flush_ready: assert property (@(posedge clock) disable iff (reset)
		(flush & disp_ready) == '0)
		else $error("thread ready during its own flush");

	a_slot0_present: assert property (@(posedge clock) disable iff (reset)
		disp.valid && disp_ready[disp.thread] |-> disp.slot[0].present)
		else $error("accepted group without slot 0");

endmodule

/* dv/rob_tb.sv */
// testbench for the two thread reorder buffer
// random dispatch and completion, model of both thread rings,
// per cycle compare of ready, tags and commit, watchdog

`timescale 1ns/1ns

`include "rob_cfg.svh"

module rob_tb;
	import rob_pkg::*;

	localparam int     NUM_TESTS   = 12;
	localparam int     TEST_CYCLES = 30;
	localparam int     DEPTH       = `ROB_DEPTH;
	localparam int     IDX_W       = `ROB_IDX_W;
	localparam longint WATCHDOG_NS = NUM_TESTS * 40 * 8;

	logic                    clock;
	logic                    reset;
	rob_disp_t               disp;
	logic [`ROB_THREADS-1:0] disp_ready;
	rob_tag_t                disp_tag [`ROB_DISP_W];
	rob_cpl_t                cpl [`ROB_CPL_PORTS];
	rob_commit_t             commit [`ROB_COMMIT_W];

	integer seed = 32'h9316;
	logic   accepted;  // group seen at the last negedge went in

	// model rings, indexed by thread and slot
	rob_payload_t     m_pay  [2][DEPTH];
	logic             m_done [2][DEPTH];
	logic             m_mis  [2][DEPTH];
	logic [IDX_W-1:0] m_head [2];
	int               m_cnt  [2];

	rob_commit_t     exp_commit [2];
	logic [1:0][1:0] n_ret;  // entries retired per thread
	logic [1:0]      exp_flush;
	logic [1:0]      exp_ready;
	rob_tag_t        exp_tag;

	rob_top u_rob_top (
		.clock      (clock),
		.reset      (reset),
		.disp       (disp),
		.disp_ready (disp_ready),
		.disp_tag   (disp_tag),
		.cpl        (cpl),
		.commit     (commit)
	);

	bind rob_top rob_assert u_rob_assert (
		.clock      (clock),
		.reset      (reset),
		.disp       (disp),
		.disp_ready (disp_ready),
		.flush      (flush),
		.commit     (commit)
	);

	initial
	begin
		clock = 1'b0;
		forever #4 clock = ~clock;
	end

	task automatic stop_run();
		$display("*** FAILED ***");
		$fatal(1, "simulation stopped at the first error");
	endtask

	task automatic compare_commit(input string name, input rob_commit_t exp,
			input rob_commit_t act);
		if (act !== exp)
		begin
			$display("Mismatch at %0t ns: %s expected %h actual %h", $time, name, exp, act);
			stop_run();
		end
	endtask

	task automatic compare_tag(input string name, input rob_tag_t exp, input rob_tag_t act);
		if (act !== exp)
		begin
			$display("Mismatch at %0t ns: %s expected %h actual %h", $time, name, exp, act);
			stop_run();
		end
	endtask

	task automatic compare_ready(input logic [1:0] exp, input logic [1:0] act);
		if (act !== exp)
		begin
			$display("Mismatch at %0t ns: disp_ready expected %b actual %b", $time, exp, act);
			stop_run();
		end
	endtask

	// entry k places behind the head of thread t is valid and done
	function automatic logic slot_done(input int t, input int k);
		logic [IDX_W-1:0] s;
		s = IDX_W'(m_head[t] + k);
		return (m_cnt[t] > k) && m_done[t][s];
	endfunction

	function automatic logic is_flush(input int t, input int k);
		logic [IDX_W-1:0] s;
		s = IDX_W'(m_head[t] + k);
		return m_mis[t][s] && m_pay[t][s].is_branch;
	endfunction

	function automatic rob_commit_t make_commit(input int t, input int k);
		rob_commit_t      c;
		logic [IDX_W-1:0] s;
		s            = IDX_W'(m_head[t] + k);
		c.valid      = 1'b1;
		c.thread     = 1'(t);
		c.mispredict = m_mis[t][s];
		c.payload    = m_pay[t][s];
		return c;
	endfunction

	// expected commit pair: thread 0 first, slot 1 stays in the same thread
	// unless slot 0 flushes, else falls over to the thread 1 head
	function automatic void ref_commit(output rob_commit_t c0, output rob_commit_t c1,
			output logic [1:0][1:0] nr, output logic [1:0] fl);
		int t0;
		c0 = '0;
		c1 = '0;
		nr = '0;
		fl = '0;
		t0 = slot_done(0, 0) ? 0 : 1;
		if (slot_done(t0, 0))
		begin
			c0     = make_commit(t0, 0);
			nr[t0] = 2'd1;
			fl[t0] = is_flush(t0, 0);
			if (!fl[t0] && slot_done(t0, 1))
			begin
				c1     = make_commit(t0, 1);
				nr[t0] = 2'd2;
				fl[t0] = is_flush(t0, 1);
			end
			else if (t0 == 0 && slot_done(1, 0))
			begin
				c1    = make_commit(1, 0);
				nr[1] = 2'd1;
				fl[1] = is_flush(1, 0);
			end
		end
	endfunction

	// apply completions, then the accepted group, then retire and flush
	task automatic update_model(input logic acc);
		int               t;
		logic [IDX_W-1:0] s;
		for (int p = 0; p < `ROB_CPL_PORTS; p++)
		begin
			t = int'(cpl[p].tag.thread);
			s = cpl[p].tag.slot;
			if (cpl[p].valid && int'(IDX_W'(s - m_head[t])) < m_cnt[t])
			begin
				m_done[t][s] = 1'b1;
				m_mis[t][s]  = cpl[p].mispredict;
			end
		end
		if (acc)
		begin
			t = int'(disp.thread);
			for (int k = 0; k < `ROB_DISP_W; k++)
			begin
				if (disp.slot[k].present)
				begin
					s            = IDX_W'(m_head[t] + m_cnt[t]);
					m_pay[t][s]  = disp.slot[k].payload;
					m_done[t][s] = 1'b0;
					m_mis[t][s]  = 1'b0;
					m_cnt[t]     = m_cnt[t] + 1;
				end
			end
		end
		for (t = 0; t < 2; t++)
		begin
			m_head[t] = IDX_W'(m_head[t] + n_ret[t]);
			m_cnt[t]  = exp_flush[t] ? 0 : m_cnt[t] - int'(n_ret[t]);
		end
	endtask

	// compare at the falling edge, where inputs and outputs are settled
	always @(negedge clock)
	begin
		if (!reset)
		begin
			ref_commit(exp_commit[0], exp_commit[1], n_ret, exp_flush);
			for (int t = 0; t < 2; t++)
				exp_ready[t] = (DEPTH - m_cnt[t] >= 2) && !exp_flush[t];
			compare_ready(exp_ready, disp_ready);
			compare_commit("commit[0]", exp_commit[0], commit[0]);
			compare_commit("commit[1]", exp_commit[1], commit[1]);
			if (disp.valid)
			begin
				for (int k = 0; k < `ROB_DISP_W; k++)
				begin
					exp_tag.thread = disp.thread;
					exp_tag.slot   = IDX_W'(m_head[disp.thread] + m_cnt[disp.thread] + k);
					compare_tag($sformatf("disp_tag[%0d]", k), exp_tag, disp_tag[k]);
				end
			end
			accepted = disp.valid && exp_ready[disp.thread];
			update_model(accepted);
		end
	end

	// a group is held until accepted, mode 1 keeps dispatch busy
	task automatic drive_dispatch(input int mode);
		if (!disp.valid || accepted)
		begin
			disp        = '0;
			disp.valid  = (mode == 1) || (($random(seed) & 3) != 0);
			disp.thread = 1'($random(seed));
			for (int k = 0; k < `ROB_DISP_W; k++)
			begin
				disp.slot[k].present           = (k == 0) || 1'($random(seed));
				disp.slot[k].payload.pc        = {$random(seed), $random(seed)};
				disp.slot[k].payload.arn       = `ROB_ARN_W'($random(seed));
				disp.slot[k].payload.prn       = `ROB_PRN_W'($random(seed));
				disp.slot[k].payload.is_branch = ($random(seed) & 3) == 0;
			end
		end
	endtask

	// complete random live entries that are not done yet, none in mode 1
	task automatic drive_completions(input int mode);
		int               t;
		int               off;
		logic [IDX_W-1:0] s;
		for (int p = 0; p < `ROB_CPL_PORTS; p++)
		begin
			cpl[p] = '0;
			t      = $random(seed) & 1;
			off    = $random(seed) & (DEPTH - 1);
			s      = IDX_W'(m_head[t] + off);
			if (mode != 1 && off < m_cnt[t] && !m_done[t][s] &&
				!(p == 1 && cpl[0].valid && cpl[0].tag == {1'(t), s}))
			begin
				cpl[p].valid      = 1'b1;
				cpl[p].tag.thread = 1'(t);
				cpl[p].tag.slot   = s;
				cpl[p].mispredict = ($random(seed) & (mode == 2 ? 1 : 7)) == 0;
			end
		end
	endtask

	initial
	begin
		reset    = 1'b1;
		disp     = '0;
		cpl[0]   = '0;
		cpl[1]   = '0;
		accepted = 1'b0;
		for (int t = 0; t < 2; t++)
		begin
			m_head[t] = '0;
			m_cnt[t]  = 0;
			for (int s = 0; s < DEPTH; s++)
			begin
				m_pay[t][s]  = '0;
				m_done[t][s] = 1'b0;
				m_mis[t][s]  = 1'b0;
			end
		end
		repeat (5) @(posedge clock);
		#1 reset = 1'b0;
		for (int n = 0; n < NUM_TESTS; n++)
		begin
			for (int c = 0; c < TEST_CYCLES; c++)
			begin
				drive_dispatch(n % 3);
				drive_completions(n % 3);
				@(posedge clock);
				#1;
			end
		end
		disp   = '0;
		cpl[0] = '0;
		cpl[1] = '0;
		@(negedge clock);
		#1;
		$display("*** PASSED ***");
		$finish;
	end

	initial
	begin
		#(WATCHDOG_NS);
		$display("timeout: run did not finish within %0d ns", WATCHDOG_NS);
		stop_run();
	end

endmodule

/* hw/rob_alloc_wb.sv */
// dispatch allocation and entry write decode
// per thread tail and occupancy, ready, tag return,
// alloc, done and clear requests for every entry

`timescale 1ns/1ns

`include "rob_cfg.svh"

module rob_alloc_wb (
	input  logic                                    clock,
	input  logic                                    reset,
	input  rob_pkg::rob_disp_t                      disp,
	input  rob_pkg::rob_cpl_t                       cpl [`ROB_CPL_PORTS],
	input  logic [`ROB_THREADS-1:0][`ROB_IDX_W-1:0] next_head,
	input  logic [`ROB_THREADS-1:0]                 flush,
	input  logic [`ROB_ENTRIES-1:0]                 retire,
	output logic [`ROB_THREADS-1:0]                 disp_ready,
	output rob_pkg::rob_tag_t                       disp_tag [`ROB_DISP_W],
	output rob_pkg::rob_wr_t                        wr [`ROB_ENTRIES]
);
	import rob_pkg::*;

	localparam int IDX_W = `ROB_IDX_W;
	localparam int ENT_W = IDX_W + 1;
	localparam int CNT_W = IDX_W + 1; // holds 0 to depth

	logic [`ROB_THREADS-1:0][IDX_W-1:0] tail;
	logic [`ROB_THREADS-1:0][CNT_W-1:0] count;
	logic                               accept;
	logic [`ROB_THREADS-1:0][1:0]       n_alloc;  // slots taken per thread this cycle
	logic [`ROB_THREADS-1:0][1:0]       n_retire;

	// ready needs room for a full group
	always_comb
	begin
		for (int t = 0; t < `ROB_THREADS; t++)
		begin
			disp_ready[t] = (count[t] <= CNT_W'(`ROB_DEPTH - 2)) && !flush[t];
		end
		accept = disp.valid && disp_ready[disp.thread];
		for (int k = 0; k < `ROB_DISP_W; k++)
		begin
			disp_tag[k].thread = disp.thread;
			disp_tag[k].slot   = tail[disp.thread] + IDX_W'(k);
		end
	end

	always_comb
	begin
		n_alloc  = '0;
		n_retire = '0;
		for (int k = 0; k < `ROB_DISP_W; k++)
		begin
			if (accept && disp.slot[k].present)
				n_alloc[disp.thread] = n_alloc[disp.thread] + 2'd1;
		end
		for (int e = 0; e < `ROB_ENTRIES; e++)
		begin
			n_retire[e / `ROB_DEPTH] = n_retire[e / `ROB_DEPTH] + 2'(retire[e]);
		end
	end

	// a tag is the flat entry index, so decode by direct compare
	always_comb
	begin
		for (int e = 0; e < `ROB_ENTRIES; e++)
		begin
			wr[e]       = '0;
			wr[e].clear = retire[e] || flush[e / `ROB_DEPTH];
			for (int k = 0; k < `ROB_DISP_W; k++)
			begin
				if (accept && disp.slot[k].present && disp_tag[k] == ENT_W'(e))
				begin
					wr[e].alloc   = 1'b1;
					wr[e].payload = disp.slot[k].payload;
				end
			end
			for (int p = 0; p < `ROB_CPL_PORTS; p++)
			begin
				if (cpl[p].valid && cpl[p].tag == ENT_W'(e))
				begin
					wr[e].done       = 1'b1;
					wr[e].mispredict = wr[e].mispredict || cpl[p].mispredict;
				end
			end
		end
	end

	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			tail  <= '0;
			count <= '0;
		end
		else
		begin
			for (int t = 0; t < `ROB_THREADS; t++)
			begin
				if (flush[t])
				begin
					tail[t]  <= next_head[t]; // drop everything younger than the branch
					count[t] <= '0;
				end
				else
				begin
					tail[t]  <= tail[t] + IDX_W'(n_alloc[t]);
					count[t] <= count[t] + CNT_W'(n_alloc[t]) - CNT_W'(n_retire[t]);
				end
			end
		end
	end

endmodule

/* hw/rob_cfg.svh */
// reorder buffer configuration macros
// thread depth, datapath widths and port counts

`ifndef ROB_CFG_SVH
`define ROB_CFG_SVH

// entries per thread ring, must be a power of two
`define ROB_DEPTH 8
`define ROB_IDX_W 3

// the commit priority is written for exactly two threads
`define ROB_THREADS 2
`define ROB_ENTRIES (`ROB_THREADS * `ROB_DEPTH)

`define ROB_PC_W  64
`define ROB_ARN_W 5  // architected register number
`define ROB_PRN_W 6  // physical register number

`define ROB_DISP_W    2  // instructions per dispatch group
`define ROB_CPL_PORTS 2  // functional unit completion ports
`define ROB_COMMIT_W  2  // retire slots per cycle

`endif

/* hw/rob_commit.sv */
// in-order commit stage
// head pointers, dual commit select with thread priority,
// retire vector and mispredict flush requests

`timescale 1ns/1ns

`include "rob_cfg.svh"

module rob_commit (
	input  logic                                    clock,
	input  logic                                    reset,
	input  rob_pkg::rob_state_t                     state [`ROB_ENTRIES],
	output rob_pkg::rob_commit_t                    commit [`ROB_COMMIT_W],
	output logic [`ROB_THREADS-1:0][`ROB_IDX_W-1:0] next_head,
	output logic [`ROB_THREADS-1:0]                 flush,
	output logic [`ROB_ENTRIES-1:0]                 retire
);
	import rob_pkg::*;

	localparam int IDX_W = `ROB_IDX_W;
	localparam int ENT_W = IDX_W + 1;

	logic [`ROB_THREADS-1:0][IDX_W-1:0]  head;
	logic [`ROB_THREADS-1:0][ENT_W-1:0]  head_ent;  // flat index of the head entry
	logic [`ROB_THREADS-1:0][ENT_W-1:0]  next_ent;  // flat index of head plus one
	logic [`ROB_THREADS-1:0]             head_ok;
	logic [`ROB_COMMIT_W-1:0]            sel_v;
	logic [`ROB_COMMIT_W-1:0]            sel_thr;
	logic [`ROB_COMMIT_W-1:0][ENT_W-1:0] sel_ent;
	logic [`ROB_COMMIT_W-1:0]            sel_mis;

	function automatic logic can_retire(input rob_state_t s);
		return s.valid && s.done;
	endfunction

	always_comb
	begin
		for (int t = 0; t < `ROB_THREADS; t++)
		begin
			head_ent[t] = {1'(t), head[t]};
			next_ent[t] = {1'(t), IDX_W'(head[t] + IDX_W'(1))};
			head_ok[t]  = can_retire(state[head_ent[t]]);
		end
	end

	always_comb
	begin
		sel_v   = '0;
		sel_thr = '0;
		sel_ent = '0;

		// slot 0, thread 0 first
		if (head_ok[0])
		begin
			sel_v[0]   = 1'b1;
			sel_thr[0] = 1'b0;
			sel_ent[0] = head_ent[0];
		end
		else if (head_ok[1])
		begin
			sel_v[0]   = 1'b1;
			sel_thr[0] = 1'b1;
			sel_ent[0] = head_ent[1];
		end
		sel_mis[0] = sel_v[0] && state[sel_ent[0]].mispredict &&
			state[sel_ent[0]].payload.is_branch;

		// slot 1 stays in the same thread unless slot 0 flushes it
		if (sel_v[0] && !sel_mis[0] && can_retire(state[next_ent[sel_thr[0]]]))
		begin
			sel_v[1]   = 1'b1;
			sel_thr[1] = sel_thr[0];
			sel_ent[1] = next_ent[sel_thr[0]];
		end
		else if (sel_v[0] && !sel_thr[0] && head_ok[1])
		begin
			sel_v[1]   = 1'b1;
			sel_thr[1] = 1'b1;
			sel_ent[1] = head_ent[1];
		end
		sel_mis[1] = sel_v[1] && state[sel_ent[1]].mispredict &&
			state[sel_ent[1]].payload.is_branch;
	end

	always_comb
	begin
		next_head = head;
		flush     = '0;
		retire    = '0;
		for (int c = 0; c < `ROB_COMMIT_W; c++)
		begin
			commit[c] = '0;
			if (sel_v[c])
			begin
				commit[c].valid      = 1'b1;
				commit[c].thread     = sel_thr[c];
				commit[c].mispredict = state[sel_ent[c]].mispredict;
				commit[c].payload    = state[sel_ent[c]].payload;
				retire[sel_ent[c]]   = 1'b1;
				next_head[sel_thr[c]] = next_head[sel_thr[c]] + IDX_W'(1);
				if (sel_mis[c])
					flush[sel_thr[c]] = 1'b1; // both threads can flush together
			end
		end
	end

	always_ff @(posedge clock)
	begin
		if (reset)
			head <= '0;
		else
			head <= next_head;
	end

endmodule

/* hw/rob_entry.sv */
// single reorder buffer entry
// payload plus valid, done and mispredict state

`timescale 1ns/1ns

`include "rob_cfg.svh"

module rob_entry (
	input  logic                clock,
	input  logic                reset,
	input  rob_pkg::rob_wr_t    wr,
	output rob_pkg::rob_state_t state
);
	import rob_pkg::*;

	rob_payload_t payload;
	logic         valid;
	logic         done;
	logic         mispredict;

	always_ff @(posedge clock)
	begin
		if (reset || wr.clear)
		begin
			valid      <= 1'b0;
			done       <= 1'b0;
			mispredict <= 1'b0;
		end
		else if (wr.alloc)
		begin
			valid      <= 1'b1;
			done       <= 1'b0;
			mispredict <= 1'b0;
		end
		else if (wr.done && valid) // late completion to a freed slot is dropped
		begin
			done       <= 1'b1;
			mispredict <= wr.mispredict;
		end
	end

	always_ff @(posedge clock)
	begin
		if (wr.alloc)
			payload <= wr.payload;
	end

	always_comb
	begin
		state.valid      = valid;
		state.done       = done;
		state.mispredict = mispredict;
		state.payload    = payload;
	end

endmodule

/* hw/rob_pkg.sv */
// shared types of the reorder buffer
// tag, payload, dispatch, completion, entry write, entry state, commit

`include "rob_cfg.svh"

package rob_pkg;

	// tag value equals the flat entry index
	typedef struct packed {
		logic                  thread;
		logic [`ROB_IDX_W-1:0] slot;
	} rob_tag_t;

	typedef struct packed {
		logic [`ROB_PC_W-1:0]  pc;
		logic [`ROB_ARN_W-1:0] arn;
		logic [`ROB_PRN_W-1:0] prn;
		logic                  is_branch;
	} rob_payload_t;

	typedef struct packed {
		logic         present;
		rob_payload_t payload;
	} rob_disp_slot_t;

	typedef struct packed {
		logic                                   valid;
		logic                                   thread;
		rob_disp_slot_t [`ROB_DISP_W-1:0] slot;  // slot 0 is the older one
	} rob_disp_t;

	typedef struct packed {
		logic     valid;
		rob_tag_t tag;
		logic     mispredict;
	} rob_cpl_t;

	typedef struct packed {
		logic         alloc;
		rob_payload_t payload;
		logic         done;
		logic         mispredict;
		logic         clear;
	} rob_wr_t;

	typedef struct packed {
		logic         valid;
		logic         done;
		logic         mispredict;
		rob_payload_t payload;
	} rob_state_t;

	typedef struct packed {
		logic         valid;
		logic         thread;
		logic         mispredict;
		rob_payload_t payload;
	} rob_commit_t;

endpackage

/* hw/rob_top.sv */
// reorder buffer top level for two hardware threads
// allocator, ring of entries per thread, commit stage

`timescale 1ns/1ns

`include "rob_cfg.svh"

module rob_top (
	input  logic                    clock,
	input  logic                    reset,
	input  rob_pkg::rob_disp_t      disp,
	output logic [`ROB_THREADS-1:0] disp_ready,
	output rob_pkg::rob_tag_t       disp_tag [`ROB_DISP_W],
	input  rob_pkg::rob_cpl_t       cpl [`ROB_CPL_PORTS],
	output rob_pkg::rob_commit_t    commit [`ROB_COMMIT_W]
);
	import rob_pkg::*;

	logic [`ROB_THREADS-1:0][`ROB_IDX_W-1:0] next_head;
	logic [`ROB_THREADS-1:0]                 flush;
	logic [`ROB_ENTRIES-1:0]                 retire;
	rob_wr_t                                 wr [`ROB_ENTRIES];
	rob_state_t                              state [`ROB_ENTRIES];

	rob_alloc_wb u_alloc_wb (
		.clock      (clock),
		.reset      (reset),
		.disp       (disp),
		.cpl        (cpl),
		.next_head  (next_head),
		.flush      (flush),
		.retire     (retire),
		.disp_ready (disp_ready),
		.disp_tag   (disp_tag),
		.wr         (wr)
	);

	// entry index is thread * depth + slot
	for (genvar i = 0; i < `ROB_ENTRIES; i++)
	begin : g_entry
		rob_entry u_entry (
			.clock (clock),
			.reset (reset),
			.wr    (wr[i]),
			.state (state[i])
		);
	end

	rob_commit u_commit (
		.clock     (clock),
		.reset     (reset),
		.state     (state),
		.commit    (commit),
		.next_head (next_head),
		.flush     (flush),
		.retire    (retire)
	);

endmodule

/* sources.f */
+incdir+hw
hw/rob_pkg.sv
hw/rob_entry.sv
hw/rob_alloc_wb.sv
hw/rob_commit.sv
hw/rob_top.sv
dv/rob_assert.sv
dv/rob_tb.sv
